// ==== lsu_pkg.sv ====
package lsu_pkg;

    // bus widths
    parameter int addr_w = 32;
    parameter int data_w = 32;
    parameter int strb_w = data_w / 8;

    // access size, same code as the core's mask field
    typedef enum logic [1:0] {
        size_none = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2,
        size_word = 2'd3
    } size_e;

    // AXI-lite response codes, only the two used here
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // controller sequence, one access at a time
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_rd_addr = 3'd1,
        st_rd_data = 3'd2,
        st_wr_addr = 3'd3,
        st_wr_data = 3'd4,
        st_wr_resp = 3'd5,
        st_finish  = 3'd6
    } ctrl_state_e;

endpackage

// ==== mem_bus_if.sv ====
`timescale 1ns/100ps

interface mem_bus_if import lsu_pkg::*; ();

    // read address and read data
    logic [addr_w-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [data_w-1:0] rdata;
    resp_e             rresp;
    logic              rvalid;
    logic              rready;

    // write address, write data, write response
    logic [addr_w-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    resp_e             bresp;
    logic              bvalid;
    logic              bready;

    modport master (
        output araddr, arvalid, rready,
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid,
        input  awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid,
        output awready, wready, bresp, bvalid
    );

endinterface

// ==== lsu_align.sv ====
`timescale 1ns/100ps

module lsu_align import lsu_pkg::*; (
    input  size_e             size,
    input  logic              sign,
    input  logic [1:0]        addr_lo,
    input  logic [data_w-1:0] store_data,
    input  logic [data_w-1:0] load_word,
    output logic [strb_w-1:0] wstrb,
    output logic [data_w-1:0] wdata_sh,
    output logic [data_w-1:0] load_data
);

    logic [4:0]        byte_sh;
    logic [data_w-1:0] shifted;

    // byte offset in bits
    assign byte_sh = {addr_lo, 3'b000};

    // store lane placement
    assign wdata_sh = store_data << byte_sh;

    always_comb begin
        case (size)
            size_byte: begin
                wstrb = 4'b0001 << addr_lo;
            end
            size_half: begin
                // bit 0 of the offset plays no part for halves
                wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            size_word: begin
                wstrb = 4'b1111;
            end
            default: begin
                wstrb = 4'b0000;
            end
        endcase
    end

    // bring the addressed lane down to bit 0
    assign shifted = load_word >> byte_sh;

    always_comb begin
        case (size)
            size_byte: begin
                load_data = {{24{shifted[7] & sign}}, shifted[7:0]};
            end
            size_half: begin
                load_data = {{16{shifted[15] & sign}}, shifted[15:0]};
            end
            size_word: begin
                load_data = shifted;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/100ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  logic              wen,
    input  logic              sign,
    input  size_e             size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output size_e             lat_size,
    output logic              lat_sign,
    output logic [1:0]        lat_addr_lo,
    output logic [data_w-1:0] lat_wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic [data_w-1:0] wdata_sh,
    output logic [data_w-1:0] load_word,
    output logic              done,
    output logic              err,
    mem_bus_if.master         bus
);

    ctrl_state_e       state;
    logic [addr_w-1:0] lat_addr;
    logic              accept;
    logic              ar_fire;
    logic              r_fire;
    logic              aw_fire;
    logic              w_fire;
    logic              b_fire;

    // a req outside idle is dropped
    assign accept = (state == st_idle) && req;

    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = bus.rvalid && bus.rready;
    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign b_fire  = bus.bvalid && bus.bready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= wen ? st_wr_addr : st_rd_addr;
                    end
                end
                st_rd_addr: begin
                    if (ar_fire) begin
                        state <= st_rd_data;
                    end
                end
                st_rd_data: begin
                    if (r_fire) begin
                        state <= st_finish;
                    end
                end
                st_wr_addr: begin
                    if (aw_fire) begin
                        state <= st_wr_data;
                    end
                end
                st_wr_data: begin
                    if (w_fire) begin
                        state <= st_wr_resp;
                    end
                end
                st_wr_resp: begin
                    if (b_fire) begin
                        state <= st_finish;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lat_size  <= size_none;
            lat_sign  <= 1'b0;
            lat_addr  <= '0;
            lat_wdata <= '0;
        end else if (accept) begin
            lat_size  <= size;
            lat_sign  <= sign;
            lat_addr  <= addr;
            lat_wdata <= wdata;
        end
    end

    assign lat_addr_lo = lat_addr[1:0];

    // returned word and status, kept until the next access ends
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_word <= '0;
            err       <= 1'b0;
        end else if (r_fire) begin
            load_word <= (bus.rresp == resp_slverr) ? '0 : bus.rdata;
            err       <= (bus.rresp == resp_slverr);
        end else if (b_fire) begin
            err <= (bus.bresp == resp_slverr);
        end
    end

    // handshake lines follow the state
    assign bus.arvalid = (state == st_rd_addr);
    assign bus.rready  = (state == st_rd_data);
    assign bus.awvalid = (state == st_wr_addr);
    assign bus.wvalid  = (state == st_wr_data);
    assign bus.bready  = (state == st_wr_resp);

    assign bus.araddr = lat_addr;
    assign bus.awaddr = lat_addr;
    assign bus.wdata  = wdata_sh;
    assign bus.wstrb  = wstrb;

    assign done = (state == st_finish);

endmodule

// ==== sram_axi.sv ====
`timescale 1ns/100ps

module sram_axi import lsu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic     clk,
    input  logic     arst_n,
    mem_bus_if.slave bus
);

    localparam int idx_w = $clog2(mem_words);
    localparam logic [addr_w-1:0] mem_bytes = addr_w'(mem_words * 4);

    // channel slots in the delay vectors
    localparam int ch_ar = 0;
    localparam int ch_r  = 1;
    localparam int ch_aw = 2;
    localparam int ch_w  = 3;
    localparam int ch_b  = 4;
    localparam int n_ch  = 5;

    logic [data_w-1:0] mem [mem_words];
    logic [7:0]        lfsr;
    logic [n_ch-1:0]   start;
    logic [n_ch-1:0]   fire;
    logic [n_ch-1:0]   armed;
    logic [n_ch-1:0]   go;
    logic [1:0]        cnt [n_ch];
    logic [addr_w-1:0] wr_addr;
    logic              rd_ok;
    logic              wr_ok;
    logic [data_w-1:0] rd_word;
    resp_e             rd_resp;
    resp_e             wr_resp;

    // x^8 + x^6 + x^5 + x^4 + 1, never reaches zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= 8'ha5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign fire[ch_ar] = bus.arvalid && bus.arready;
    assign fire[ch_r]  = bus.rvalid && bus.rready;
    assign fire[ch_aw] = bus.awvalid && bus.awready;
    assign fire[ch_w]  = bus.wvalid && bus.wready;
    assign fire[ch_b]  = bus.bvalid && bus.bready;

    // response channels start on the transfer that feeds them
    assign start[ch_ar] = bus.arvalid;
    assign start[ch_r]  = fire[ch_ar];
    assign start[ch_aw] = bus.awvalid;
    assign start[ch_w]  = bus.wvalid;
    assign start[ch_b]  = fire[ch_w];

    // per channel wait of 0 to 3 cycles once armed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            armed <= '0;
            for (int i = 0; i < n_ch; i++) begin
                cnt[i] <= 2'd0;
            end
        end else begin
            for (int i = 0; i < n_ch; i++) begin
                if (fire[i]) begin
                    armed[i] <= 1'b0;
                end else if (start[i] && !armed[i]) begin
                    armed[i] <= 1'b1;
                    cnt[i]   <= lfsr[(2 * i) % 8 +: 2];
                end else if (armed[i] && (cnt[i] != 2'd0)) begin
                    cnt[i] <= cnt[i] - 2'd1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < n_ch; i++) begin
            go[i] = armed[i] && (cnt[i] == 2'd0);
        end
    end

    assign bus.arready = go[ch_ar];
    assign bus.rvalid  = go[ch_r];
    assign bus.awready = go[ch_aw];
    assign bus.wready  = go[ch_w];
    assign bus.bvalid  = go[ch_b];

    assign rd_ok = (bus.araddr < mem_bytes);
    assign wr_ok = (wr_addr < mem_bytes);

    // memory array and channel payloads
    always_ff @(posedge clk) begin
        if (fire[ch_ar]) begin
            rd_word <= rd_ok ? mem[bus.araddr[idx_w+1:2]] : '0;
            rd_resp <= rd_ok ? resp_okay : resp_slverr;
        end
        if (fire[ch_aw]) begin
            wr_addr <= bus.awaddr;
        end
        if (fire[ch_w]) begin
            wr_resp <= wr_ok ? resp_okay : resp_slverr;
            if (wr_ok) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (bus.wstrb[b]) begin
                        mem[wr_addr[idx_w+1:2]][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus.rdata = rd_word;
    assign bus.rresp = rd_resp;
    assign bus.bresp = wr_resp;

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  logic              wen,
    input  logic              sign,
    input  logic [1:0]        size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              done,
    output logic              err
);

    size_e             lat_size;
    logic              lat_sign;
    logic [1:0]        lat_addr_lo;
    logic [data_w-1:0] lat_wdata;
    logic [strb_w-1:0] wstrb;
    logic [data_w-1:0] wdata_sh;
    logic [data_w-1:0] load_word;

    mem_bus_if u_bus ();

    // lane shifting for both directions
    lsu_align u_align (
        .size       (lat_size),
        .sign       (lat_sign),
        .addr_lo    (lat_addr_lo),
        .store_data (lat_wdata),
        .load_word  (load_word),
        .wstrb      (wstrb),
        .wdata_sh   (wdata_sh),
        .load_data  (rdata)
    );

    lsu_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .wen         (wen),
        .sign        (sign),
        .size        (size_e'(size)),
        .addr        (addr),
        .wdata       (wdata),
        .lat_size    (lat_size),
        .lat_sign    (lat_sign),
        .lat_addr_lo (lat_addr_lo),
        .lat_wdata   (lat_wdata),
        .wstrb       (wstrb),
        .wdata_sh    (wdata_sh),
        .load_word   (load_word),
        .done        (done),
        .err         (err),
        .bus         (u_bus.master)
    );

    sram_axi #(
        .mem_words (mem_words)
    ) u_sram (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (u_bus.slave)
    );

endmodule

// ==== tb_lsu.sv ====
`timescale 1ns/100ps

module tb_lsu;

    localparam int max_vec   = 128;
    localparam int done_wait = 40;

    // op column tokens as read by %s, right aligned
    localparam logic [63:0] op_read  = {32'd0, "read"};
    localparam logic [63:0] op_write = {24'd0, "write"};
    localparam logic [63:0] op_note  = {56'd0, "#"};

    logic        clk;
    logic        arst_n;
    logic        req;
    logic        wen;
    logic        sign;
    logic [1:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic        err;

    // vector table from the input file
    logic        v_wen   [max_vec];
    logic [1:0]  v_size  [max_vec];
    logic        v_sign  [max_vec];
    logic [31:0] v_addr  [max_vec];
    logic [31:0] v_wdata [max_vec];
    logic [31:0] v_rdata [max_vec];
    logic        v_err   [max_vec];
    int          n_vec;

    int seed;
    int err_cnt;
    int check_cnt;
    int done_cnt;
    int req_cnt;
    int cycle_cnt;
    int cycle_limit;

    lsu_top #(
        .mem_words (256)
    ) u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .wen    (wen),
        .sign   (sign),
        .size   (size),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .done   (done),
        .err    (err)
    );

    always #2 clk = ~clk;

    // every done pulse counts, expected or not
    always @(negedge clk) begin
        if (arst_n && done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d  errors: %0d", check_cnt, err_cnt + 1);
            $display("Errors found");
            $finish;
        end
    end

    task automatic load_vectors();
        int            fd;
        int            code;
        logic [63:0]   op_txt;
        logic [1023:0] line_buf;
        int            f_size;
        int            f_sign;
        logic [31:0]   f_addr;
        logic [31:0]   f_wdata;
        logic [31:0]   f_rdata;
        int            f_err;
        n_vec = 0;
        fd = $fopen("lsu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open lsu_input.txt");
            err_cnt++;
            return;
        end
        code = $fscanf(fd, "%s", op_txt);
        while (code == 1) begin
            if (op_txt == op_note) begin
                // skip the rest of a comment line
                code = $fgets(line_buf, fd);
            end else begin
                code = $fscanf(fd, "%d %d %h %h %h %d",
                               f_size, f_sign, f_addr, f_wdata, f_rdata, f_err);
                if (code != 6 || n_vec >= max_vec ||
                    (op_txt != op_read && op_txt != op_write)) begin
                    $display("malformed line in lsu_input.txt after vector %0d", n_vec);
                    err_cnt++;
                    break;
                end
                v_wen[n_vec]   = (op_txt == op_write);
                v_size[n_vec]  = f_size[1:0];
                v_sign[n_vec]  = f_sign[0];
                v_addr[n_vec]  = f_addr;
                v_wdata[n_vec] = f_wdata;
                v_rdata[n_vec] = f_rdata;
                v_err[n_vec]   = f_err[0];
                n_vec++;
            end
            code = $fscanf(fd, "%s", op_txt);
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("lsu_input.txt holds no vectors");
            err_cnt++;
        end
    endtask

    task automatic run_access(input int idx);
        int   gap;
        int   waited;
        logic pulse;
        gap   = $unsigned($random(seed)) % 4;
        pulse = ((idx % 4) == 3);
        repeat (gap) @(negedge clk);
        @(negedge clk);
        req   = 1'b1;
        wen   = v_wen[idx];
        sign  = v_sign[idx];
        size  = v_size[idx];
        addr  = v_addr[idx];
        wdata = v_wdata[idx];
        req_cnt++;
        @(negedge clk);
        req    = 1'b0;
        waited = 0;
        while (!done && waited < done_wait) begin
            @(negedge clk);
            waited++;
            if (pulse && waited == 1 && !done) begin
                // second request while busy, must be dropped
                req  = 1'b1;
                wen  = ~wen;
                size = 2'd3;
                addr = 32'h0000_0008;
            end else begin
                req = 1'b0;
            end
        end
        if (!done) begin
            $display("vector %0d: done did not arrive within %0d cycles", idx, done_wait);
            err_cnt++;
        end else begin
            if (!v_wen[idx]) begin
                check_cnt++;
                if (rdata !== v_rdata[idx]) begin
                    $display("Error: vector %0d rdata expected %h actual %h",
                             idx, v_rdata[idx], rdata);
                    err_cnt++;
                end
            end
            check_cnt++;
            if (err !== v_err[idx]) begin
                $display("Error: vector %0d err expected %b actual %b",
                         idx, v_err[idx], err);
                err_cnt++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        req         = 1'b0;
        wen         = 1'b0;
        sign        = 1'b0;
        size        = 2'd0;
        addr        = 32'd0;
        wdata       = 32'd0;
        seed        = 32'h4c25_0fd3;
        err_cnt     = 0;
        check_cnt   = 0;
        done_cnt    = 0;
        req_cnt     = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        load_vectors();
        cycle_limit = 20 * n_vec + 50;
        repeat (5) @(negedge clk);
        check_cnt = check_cnt + 2;
        if (done !== 1'b0) begin
            $display("Error: reset done expected 0 actual %b", done);
            err_cnt++;
        end
        if (rdata !== 32'd0) begin
            $display("Error: reset rdata expected %h actual %h", 32'd0, rdata);
            err_cnt++;
        end
        arst_n = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            run_access(i);
        end
        // let a stray trailing done show up in the count
        repeat (4) @(negedge clk);
        if (done_cnt != req_cnt) begin
            $display("done pulse count %0d does not match %0d accepted requests",
                     done_cnt, req_cnt);
            err_cnt++;
        end
        $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== lsu_input.txt ====
# op size(0 none 1 byte 2 half 3 word) sign addr wdata exp_rdata exp_err
# addr, wdata and exp_rdata in hex, exp_rdata ignored on writes
write 3 0 00000000 12345678 00000000 0
write 3 0 00000004 deadbeef 00000000 0
write 3 0 000003fc a5a55a5a 00000000 0
read  3 0 00000000 00000000 12345678 0
read  3 0 00000004 00000000 deadbeef 0
read  3 0 000003fc 00000000 a5a55a5a 0
write 3 0 00000010 11223344 00000000 0
write 1 0 00000010 000000aa 00000000 0
write 1 0 00000011 000000bb 00000000 0
write 1 0 00000012 000000cc 00000000 0
write 1 0 00000013 000000dd 00000000 0
read  3 0 00000010 00000000 ddccbbaa 0
write 3 0 00000014 55667788 00000000 0
write 2 0 00000014 0000beef 00000000 0
write 2 0 00000016 0000cafe 00000000 0
read  3 0 00000014 00000000 cafebeef 0
write 3 0 00000018 01020304 00000000 0
write 1 0 00000019 ffffff9e 00000000 0
read  3 0 00000018 00000000 01029e04 0
write 3 0 00000020 80f17f86 00000000 0
read  1 1 00000020 00000000 ffffff86 0
read  1 1 00000021 00000000 0000007f 0
read  1 1 00000022 00000000 fffffff1 0
read  1 1 00000023 00000000 ffffff80 0
read  1 0 00000020 00000000 00000086 0
read  1 0 00000021 00000000 0000007f 0
read  1 0 00000022 00000000 000000f1 0
read  1 0 00000023 00000000 00000080 0
read  2 1 00000020 00000000 00007f86 0
read  2 1 00000022 00000000 ffff80f1 0
read  2 1 00000021 00000000 fffff17f 0
read  2 1 00000023 00000000 00000080 0
read  2 0 00000022 00000000 000080f1 0
read  2 0 00000021 00000000 0000f17f 0
write 0 0 00000020 ffffffff 00000000 0
read  3 0 00000020 00000000 80f17f86 0
read  0 1 00000020 00000000 00000000 0
write 3 0 00000400 11111111 00000000 1
read  3 0 00000000 00000000 12345678 0
read  3 0 00000400 00000000 00000000 1
read  1 1 00000403 00000000 00000000 1
write 1 0 0000ffff 000000ee 00000000 1
read  3 0 000003fc 00000000 a5a55a5a 0
read  3 0 00000004 00000000 deadbeef 0

// ==== sim.f ====
lsu_pkg.sv
mem_bus_if.sv
lsu_align.sv
lsu_ctrl.sv
sram_axi.sv
lsu_top.sv
tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# build the LSU testbench with Verilator, run it, then scan the log
verilator --binary -f sim.f --top-module tb_lsu -o tb_lsu_sim \
    && { ./obj_dir/tb_lsu_sim > sim.log 2>&1; cat sim.log; } \
    && ! grep -q "Errors found" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
